/* verilog/eeprom_cfg.svh */
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// clk cycles per quarter of an scl period
`define EE_QTR_CYCLES 4

// 24c16 style device code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// axi4-lite byte address width
`define EE_AXI_AW 4

// register map, byte offsets
`define EE_REG_ADDR   4'h0
`define EE_REG_WDATA  4'h4
`define EE_REG_CTRL   4'h8
`define EE_REG_STATUS 4'hC

`endif

/* verilog/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // host command, register block to controller
    typedef struct packed {
        logic        rd;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } ee_cmd_t;

    // transfer result back to the register block
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } ee_rsp_t;

    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] tx_byte;
        logic       master_ack;  // reads only, 1 drives ack low
    } bit_req_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_ack;   // 1 when slave pulled sda low
    } bit_rsp_t;

endpackage

`default_nettype wire

/* verilog/axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module axil_regs (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [`EE_AXI_AW-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [31:0]           s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [`EE_AXI_AW-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [31:0]           s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output eeprom_pkg::ee_cmd_t   cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    input  eeprom_pkg::ee_rsp_t   rsp,
    input  logic                  rsp_valid
);

    logic [10:0] addr_q;
    logic [7:0]  wdata_q;
    logic        rd_q;
    logic        busy_q;
    logic        done_q;
    logic        nack_q;
    logic [7:0]  rdata_q;
    logic        wr_fire;
    logic        rd_fire;
    logic        go_fire;
    logic        aw_take;
    logic [31:0] rd_mux;

    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    assign aw_take = s_awvalid && s_wvalid && !s_awready && !s_bvalid;
    assign wr_fire = s_awready && s_awvalid && s_wvalid;
    assign rd_fire = s_arready && s_arvalid;
    // go ignored while a transfer is in flight
    assign go_fire = wr_fire && (s_awaddr == `EE_REG_CTRL) && s_wdata[0] && !busy_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end
        else
        begin
            s_awready <= aw_take;
            s_wready  <= aw_take;
            if (wr_fire)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;
            s_arready <= s_arvalid && !s_arready && !s_rvalid;
            if (rd_fire)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr_q    <= '0;
            wdata_q   <= '0;
            rd_q      <= 1'b0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            rdata_q   <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            if (wr_fire)
            begin
                case (s_awaddr)
                    `EE_REG_ADDR:  addr_q  <= s_wdata[10:0];
                    `EE_REG_WDATA: wdata_q <= s_wdata[7:0];
                    `EE_REG_CTRL:
                    begin
                        rd_q   <= s_wdata[1];
                        done_q <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (go_fire)
            begin
                cmd_valid <= 1'b1;
                busy_q    <= 1'b1;
            end
            if (rsp_valid)
            begin
                busy_q  <= 1'b0;
                done_q  <= 1'b1;
                nack_q  <= rsp.nack;
                rdata_q <= rsp.rdata;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (go_fire)
            cmd <= '{rd: s_wdata[1], addr: addr_q, wdata: wdata_q};
        if (rd_fire)
            s_rdata <= rd_mux;
    end

    always_comb
    begin
        case (s_araddr)
            `EE_REG_ADDR:   rd_mux = {21'd0, addr_q};
            `EE_REG_WDATA:  rd_mux = {24'd0, wdata_q};
            `EE_REG_CTRL:   rd_mux = {30'd0, rd_q, 1'b0};  // go reads as 0
            `EE_REG_STATUS: rd_mux = {16'd0, rdata_q, 5'd0, nack_q, done_q, busy_q};
            default:        rd_mux = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/i2c_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_ctrl (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::ee_cmd_t  cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output eeprom_pkg::ee_rsp_t  rsp,
    output logic                 rsp_valid,
    output eeprom_pkg::bit_req_t req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  eeprom_pkg::bit_rsp_t op_rsp,
    input  logic                 op_done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } state_e;

    state_e              state;
    state_e              state_nxt;
    eeprom_pkg::ee_cmd_t cmd_q;
    logic                wait_q;  // request accepted, op_done pending

    assign cmd_ready = (state == S_IDLE);
    assign req_valid = (state != S_IDLE) && !wait_q;

    always_comb
    begin
        req.op         = eeprom_pkg::OP_STOP;
        req.tx_byte    = 8'h00;
        req.master_ack = 1'b0;
        case (state)
            S_START, S_RSTART:
                req.op = eeprom_pkg::OP_START;
            S_CTRL_W:
            begin
                req.op      = eeprom_pkg::OP_WRITE;
                req.tx_byte = {`EE_DEV_CODE, cmd_q.addr[10:8], 1'b0};
            end
            S_ADDR:
            begin
                req.op      = eeprom_pkg::OP_WRITE;
                req.tx_byte = cmd_q.addr[7:0];
            end
            S_DATA:
            begin
                req.op      = eeprom_pkg::OP_WRITE;
                req.tx_byte = cmd_q.wdata;
            end
            S_CTRL_R:
            begin
                req.op      = eeprom_pkg::OP_WRITE;
                req.tx_byte = {`EE_DEV_CODE, cmd_q.addr[10:8], 1'b1};
            end
            S_READ:
                req.op = eeprom_pkg::OP_READ;  // single byte, master nack
            default: ;
        endcase
    end

    // any slave nack goes straight to stop
    always_comb
    begin
        case (state)
            S_START:  state_nxt = S_CTRL_W;
            S_CTRL_W: state_nxt = op_rsp.slave_ack ? S_ADDR : S_STOP;
            S_ADDR:
            begin
                if (!op_rsp.slave_ack)
                    state_nxt = S_STOP;
                else if (cmd_q.rd)
                    state_nxt = S_RSTART;
                else
                    state_nxt = S_DATA;
            end
            S_DATA:   state_nxt = S_STOP;
            S_RSTART: state_nxt = S_CTRL_R;
            S_CTRL_R: state_nxt = op_rsp.slave_ack ? S_READ : S_STOP;
            S_READ:   state_nxt = S_STOP;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            wait_q    <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (req_valid && req_ready)
                wait_q <= 1'b1;
            if (state == S_IDLE)
            begin
                if (cmd_valid)
                    state <= S_START;
            end
            else if (op_done)
            begin
                wait_q <= 1'b0;
                state  <= state_nxt;
                if (state == S_STOP)
                    rsp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            cmd_q     <= cmd;
            rsp.nack  <= 1'b0;
            rsp.rdata <= 8'h00;
        end
        if (op_done)
        begin
            if (req.op == eeprom_pkg::OP_WRITE && !op_rsp.slave_ack)
                rsp.nack <= 1'b1;
            if (state == S_READ)
                rsp.rdata <= op_rsp.rx_byte;
        end
    end

endmodule

`default_nettype wire

/* verilog/i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bit_req_t req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output eeprom_pkg::bit_rsp_t op_rsp,
    output logic                 op_done,
    output logic                 scl,
    output logic                 sda_low,
    input  logic                 sda_in
);

    localparam int QW = $clog2(`EE_QTR_CYCLES + 1);

    logic                busy;
    eeprom_pkg::bit_op_e op_q;
    logic [7:0]          tx_q;
    logic                mack_q;
    logic [QW-1:0]       qcnt;
    logic                qtick;
    logic [5:0]          step;       // quarter index within the operation
    logic [5:0]          last_step;
    logic [1:0]          drive_fin;
    logic [1:0]          drive_nxt;
    logic                data_op;

    // {scl, sda_low} for a given quarter; data bits are 4 quarters, scl high in 1 and 2
    function automatic logic [1:0] line_drive(input eeprom_pkg::bit_op_e op,
                                              input logic [5:0] st,
                                              input logic [7:0] tx,
                                              input logic mack);
        logic [3:0] b;
        logic       d;
        b = st[5:2];
        d = 1'b0;
        case (op)
            eeprom_pkg::OP_START: line_drive = {1'b1, st[0]};            // sda falls in q1
            eeprom_pkg::OP_STOP:  line_drive = {st != 6'd0, st != 6'd2};  // sda rises in q2
            default:
            begin
                if (b < 4'd8)
                    d = (op == eeprom_pkg::OP_WRITE) ? ~tx[3'd7 - b[2:0]] : 1'b0;
                else
                    d = (op == eeprom_pkg::OP_READ) ? mack : 1'b0;  // ack slot
                line_drive = {st[1:0] == 2'd1 || st[1:0] == 2'd2, d};
            end
        endcase
    endfunction

    assign req_ready = ~busy;
    assign qtick     = busy && (qcnt == QW'(`EE_QTR_CYCLES - 1));
    assign data_op   = (op_q == eeprom_pkg::OP_WRITE) || (op_q == eeprom_pkg::OP_READ);
    assign drive_nxt = line_drive(op_q, step + 6'd1, tx_q, mack_q);

    always_comb
    begin
        case (op_q)
            eeprom_pkg::OP_START:
            begin
                last_step = 6'd1;
                drive_fin = 2'b01;  // scl low, hold sda low
            end
            eeprom_pkg::OP_STOP:
            begin
                last_step = 6'd2;
                drive_fin = 2'b10;  // bus released
            end
            default:
            begin
                last_step = 6'd35;
                drive_fin = 2'b00;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_done <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            qcnt    <= '0;
            step    <= '0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!busy)
            begin
                if (req_valid)
                begin
                    busy           <= 1'b1;
                    qcnt           <= '0;
                    step           <= '0;
                    {scl, sda_low} <= line_drive(req.op, 6'd0, req.tx_byte, req.master_ack);
                end
            end
            else
            begin
                qcnt <= qtick ? '0 : qcnt + 1'b1;
                if (qtick && step == last_step)
                begin
                    busy           <= 1'b0;
                    op_done        <= 1'b1;
                    {scl, sda_low} <= drive_fin;
                end
                else if (qtick)
                begin
                    step           <= step + 6'd1;
                    {scl, sda_low} <= drive_nxt;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy && req_valid)
        begin
            op_q   <= req.op;
            tx_q   <= req.tx_byte;
            mack_q <= req.master_ack;
        end
        // sample at the q1 to q2 boundary, scl high
        if (qtick && data_op && step[1:0] == 2'd1)
        begin
            if (step[5:2] < 4'd8)
                op_rsp.rx_byte <= {op_rsp.rx_byte[6:0], sda_in};
            else
                op_rsp.slave_ack <= ~sda_in;
        end
    end

endmodule

`default_nettype wire

/* verilog/eeprom_i2c_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_i2c_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic [`EE_AXI_AW-1:0] s_awaddr,
    input  logic                  s_awvalid,
    output logic                  s_awready,
    input  logic [31:0]           s_wdata,
    input  logic                  s_wvalid,
    output logic                  s_wready,
    output logic [1:0]            s_bresp,
    output logic                  s_bvalid,
    input  logic                  s_bready,
    input  logic [`EE_AXI_AW-1:0] s_araddr,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output logic [31:0]           s_rdata,
    output logic [1:0]            s_rresp,
    output logic                  s_rvalid,
    input  logic                  s_rready,
    output logic                  scl,
    output logic                  sda_low,
    input  logic                  sda_in
);

    eeprom_pkg::ee_cmd_t  cmd;
    logic                 cmd_valid;
    logic                 cmd_ready;
    eeprom_pkg::ee_rsp_t  rsp;
    logic                 rsp_valid;
    eeprom_pkg::bit_req_t req;
    logic                 req_valid;
    logic                 req_ready;
    eeprom_pkg::bit_rsp_t op_rsp;
    logic                 op_done;

    axil_regs u_regs (
        .CLK, .RESET,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .cmd, .cmd_valid, .cmd_ready,
        .rsp, .rsp_valid
    );

    i2c_ctrl u_ctrl (
        .CLK, .RESET,
        .cmd, .cmd_valid, .cmd_ready,
        .rsp, .rsp_valid,
        .req, .req_valid, .req_ready,
        .op_rsp, .op_done
    );

    i2c_bit_engine u_engine (
        .CLK, .RESET,
        .req, .req_valid, .req_ready,
        .op_rsp, .op_done,
        .scl, .sda_low, .sda_in
    );

endmodule

`default_nettype wire

/* testbench/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_pull,
    output int   stop_count
);

    localparam logic [1:0] M_IDLE = 2'd0;
    localparam logic [1:0] M_RX   = 2'd1;
    localparam logic [1:0] M_TX   = 2'd2;
    localparam logic [1:0] M_SKIP = 2'd3;  // nacked, wait for stop

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [7:0]  sh;
    logic [7:0]  tx_byte;
    logic [1:0]  mode;
    logic [3:0]  bit_cnt;
    int          byte_idx;
    logic        rd_pend;
    logic        clocked;   // rising scl seen since the last start
    logic        scl_q;
    logic        sda_q;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ 8'h5A ^ {i[10:8], 5'd0};
        sda_pull   = 1'b0;
        stop_count = 0;
        mode       = M_IDLE;
        clocked    = 1'b0;
        rd_pend    = 1'b0;
    end

    // end of bit 7 of a received byte
    task automatic accept_byte;
        logic ack;
        ack = !force_nack;
        case (byte_idx)
            0:
            begin
                ack       = ack && (sh[7:4] == `EE_DEV_CODE);
                ptr[10:8] = sh[3:1];  // block bits
                rd_pend   = sh[0];
            end
            1: ptr[7:0] = sh;
            2:
            begin
                if (ack)
                    mem[ptr] = sh;
            end
            default: ack = 1'b0;  // no page writes
        endcase
        byte_idx++;
        sda_pull = ack;
        if (!ack)
        begin
            mode    = M_SKIP;
            rd_pend = 1'b0;
        end
    endtask

    task automatic scl_falling;
        if (bit_cnt < 4'd7)
        begin
            bit_cnt++;
            if (mode == M_TX)
                sda_pull = ~tx_byte[7 - bit_cnt];
        end
        else if (bit_cnt == 4'd7)
        begin
            bit_cnt = 4'd8;
            if (mode == M_TX)
                sda_pull = 1'b0;      // master's ack slot
            else
                accept_byte();
        end
        else
        begin
            bit_cnt  = 4'd0;
            sda_pull = 1'b0;
            if (mode == M_TX)
                mode = M_SKIP;        // single byte read only
            else if (rd_pend)
            begin
                mode     = M_TX;
                rd_pend  = 1'b0;
                tx_byte  = mem[ptr];
                sda_pull = ~tx_byte[7];
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            mode     = M_RX;          // start or repeated start
            byte_idx = 0;
            bit_cnt  = 4'd0;
            rd_pend  = 1'b0;
            clocked  = 1'b0;
            sda_pull = 1'b0;
        end
        else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            if (mode != M_IDLE)
                stop_count++;
            mode     = M_IDLE;
            clocked  = 1'b0;
            sda_pull = 1'b0;
        end
        else if (scl_q === 1'b0 && scl === 1'b1)
        begin
            clocked = 1'b1;
            if (mode == M_RX && bit_cnt < 4'd8)
                sh = {sh[6:0], sda};
        end
        else if (scl_q === 1'b1 && scl === 1'b0 && clocked)
        begin
            clocked = 1'b0;
            if (mode == M_RX || mode == M_TX)
                scl_falling();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

/* testbench/eeprom_i2c_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_asserts (
    input logic        CLK,
    input logic        RESET,
    input logic        scl,
    input logic        sda_low,
    input logic        sda_in,
    input logic        data_op,
    input logic        s_bvalid,
    input logic        s_bready,
    input logic        s_rvalid,
    input logic        s_rready,
    input logic [31:0] s_rdata
);

    int fail_count;

    initial
        fail_count = 0;

    // inside a byte sda holds while scl is high
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $changed(sda_in) |-> !data_op)
    else
    begin
        $error("sda changed while scl was high inside a byte");
        fail_count++;
    end

    a_bvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        s_bvalid && !s_bready |=> s_bvalid)
    else
    begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    a_rvalid_hold: assert property (@(posedge CLK) disable iff (RESET)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else
    begin
        $error("read response changed before rready");
        fail_count++;
    end

    a_bus_idle: assert property (@(posedge CLK)
        $past(RESET) && !RESET |-> scl && !sda_low)
    else
    begin
        $error("bus not released after reset");
        fail_count++;
    end

endmodule

bind eeprom_i2c_top eeprom_i2c_asserts u_asserts (
    .CLK(CLK), .RESET(RESET),
    .scl(scl), .sda_low(sda_low), .sda_in(sda_in),
    .data_op(u_engine.data_op),
    .s_bvalid(s_bvalid), .s_bready(s_bready),
    .s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata)
);

`default_nettype wire

/* testbench/tb_eeprom_i2c.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_cfg.svh"

module tb_eeprom_i2c;

    localparam int XFER_CYCLES    = 8 * 36 * `EE_QTR_CYCLES;   // longest transfer is a read
    localparam int TIMEOUT_CYCLES = 60 * XFER_CYCLES + 30000;  // about 100k

    logic                  CLK;
    logic                  RESET;
    logic [`EE_AXI_AW-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [31:0]           s_wdata;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [`EE_AXI_AW-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [31:0]           s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;
    logic                  scl;
    logic                  sda_low;
    logic                  ee_pull;
    logic                  force_nack;
    int                    ee_stops;
    wire                   sda;

    integer      seed;
    int          errors;
    int          checks;
    int          cycle_cnt;
    string       cur_test;
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       cmp_name;
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    logic [7:0]  ref_data [0:2047];
    logic        written [0:2047];

    assign sda = !(sda_low || ee_pull);  // open drain with pull-up

    eeprom_i2c_top DUT (
        .CLK, .RESET,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .scl, .sda_low, .sda_in(sda)
    );

    eeprom_model u_eeprom (
        .scl, .sda, .force_nack,
        .sda_pull(ee_pull), .stop_count(ee_stops)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("timeout: no end of test after %0d cycles", cycle_cnt);
        $display("Simulation FAILED");
        $finish;
    end

    // low byte xor 5a with block bits folded in unless written
    function automatic logic [7:0] ref_byte(input logic [10:0] a);
        if (written[a])
            return ref_data[a];
        return a[7:0] ^ 8'h5A ^ {a[10:8], 5'd0};
    endfunction

    function automatic int rand_hold();
        return 1 + ($unsigned($random(seed)) % 8);
    endfunction

    task automatic expect_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        name_q.push_back({cur_test, ": ", what});
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    initial
    begin
        forever
        begin
            @(posedge CLK);
            while (act_q.size() > 0)
            begin
                cmp_name = name_q.pop_front();
                cmp_exp  = exp_q.pop_front();
                cmp_act  = act_q.pop_front();
                checks++;
                assert (cmp_act === cmp_exp)
                else
                begin
                    $display("** Error: %s expected %0h actual %0h", cmp_name, cmp_exp, cmp_act);
                    errors++;
                end
            end
        end
    end

    // called and returns on a falling edge
    task automatic axi_write(input logic [`EE_AXI_AW-1:0] a, input logic [31:0] d,
                             input int hold);
        s_awaddr  = a;
        s_wdata   = d;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        @(negedge CLK);
        while (!s_awready)
            @(negedge CLK);
        @(negedge CLK);  // handshake on the edge in between
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid)
            @(negedge CLK);
        expect_value("bresp", 32'h0, {30'd0, s_bresp});
        repeat (hold)
        begin
            @(negedge CLK);
            assert (s_bvalid && s_bresp == 2'b00)
            else
            begin
                $display("%s: write response dropped before bready", cur_test);
                errors++;
            end
        end
        s_bready = 1'b1;
        @(negedge CLK);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`EE_AXI_AW-1:0] a, input int hold,
                            output logic [31:0] data);
        logic [31:0] first;
        s_araddr  = a;
        s_arvalid = 1'b1;
        @(negedge CLK);
        while (!s_arready)
            @(negedge CLK);
        @(negedge CLK);
        s_arvalid = 1'b0;
        while (!s_rvalid)
            @(negedge CLK);
        first = s_rdata;
        expect_value("rresp", 32'h0, {30'd0, s_rresp});
        repeat (hold)
        begin
            @(negedge CLK);
            assert (s_rvalid && s_rdata === first)
            else
            begin
                $display("%s: read response changed before rready", cur_test);
                errors++;
            end
        end
        data     = s_rdata;
        s_rready = 1'b1;
        @(negedge CLK);
        s_rready = 1'b0;
    endtask

    task automatic run_xfer(input logic [10:0] a, input logic [7:0] d, input logic rd,
                            input int hold, output logic [31:0] status);
        axi_write(`EE_REG_ADDR, {21'd0, a}, hold);
        axi_write(`EE_REG_WDATA, {24'd0, d}, hold);
        axi_write(`EE_REG_CTRL, {30'd0, rd, 1'b1}, hold);
        status = '0;
        while (!status[1])
            axi_read(`EE_REG_STATUS, hold, status);
    endtask

    task automatic end_test(input int errs_before);
        while (act_q.size() > 0)
            @(negedge CLK);
        $display("%-28s done, %0d errors", cur_test, errors - errs_before);
    endtask

    initial
    begin
        logic [31:0] rd;
        logic [10:0] a;
        logic [7:0]  d;
        int          errs;
        int          stops0;
        int          afails;
        seed       = 32'hf8e5;
        errors     = 0;
        checks     = 0;
        RESET      = 1'b1;
        s_awaddr   = '0;
        s_awvalid  = 1'b0;
        s_wdata    = '0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b0;
        s_araddr   = '0;
        s_arvalid  = 1'b0;
        s_rready   = 1'b0;
        force_nack = 1'b0;
        for (int i = 0; i < 2048; i++)
            written[i] = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);

        cur_test = "reset and registers";
        errs = errors;
        axi_read(`EE_REG_STATUS, 0, rd);
        expect_value("status", 32'h0, rd);
        expect_value("bus idle", 32'h3, {30'd0, scl, sda});
        axi_write(`EE_REG_ADDR, 32'h5A3, 0);
        axi_read(`EE_REG_ADDR, 0, rd);
        expect_value("addr readback", 32'h5A3, rd);
        axi_write(`EE_REG_WDATA, 32'hC3, 0);
        axi_read(`EE_REG_WDATA, 0, rd);
        expect_value("wdata readback", 32'hC3, rd);
        end_test(errs);

        cur_test = "random write and read";
        errs = errors;
        repeat (20)
        begin
            a = 11'($random(seed));
            d = 8'($random(seed));
            run_xfer(a, d, 1'b0, 0, rd);
            expect_value("write flags", 32'h2, {29'd0, rd[2:0]});
            written[a]  = 1'b1;
            ref_data[a] = d;
            run_xfer(a, 8'h00, 1'b1, 0, rd);
            expect_value("read flags", 32'h2, {29'd0, rd[2:0]});
            expect_value("read data", {24'd0, ref_byte(a)}, {24'd0, rd[15:8]});
        end
        end_test(errs);

        cur_test = "unwritten fill";
        errs = errors;
        repeat (6)
        begin
            a = 11'($random(seed));
            while (written[a])
                a = a + 11'd1;
            run_xfer(a, 8'h00, 1'b1, 0, rd);
            expect_value("fill data", {24'd0, ref_byte(a)}, {24'd0, rd[15:8]});
        end
        end_test(errs);

        cur_test = "forced nack";
        errs = errors;
        a = 11'($random(seed));
        d = ~ref_byte(a);
        force_nack = 1'b1;
        run_xfer(a, d, 1'b0, 0, rd);
        expect_value("nack flags", 32'h6, {29'd0, rd[2:0]});
        force_nack = 1'b0;
        run_xfer(a, 8'h00, 1'b1, 0, rd);
        expect_value("flags after nack", 32'h2, {29'd0, rd[2:0]});
        expect_value("data after nack", {24'd0, ref_byte(a)}, {24'd0, rd[15:8]});
        end_test(errs);

        cur_test = "back-pressure and busy go";
        errs = errors;
        stops0 = ee_stops;
        a = 11'($random(seed));
        d = 8'($random(seed));
        axi_write(`EE_REG_ADDR, {21'd0, a}, rand_hold());
        axi_write(`EE_REG_WDATA, {24'd0, d}, rand_hold());
        axi_write(`EE_REG_CTRL, 32'h1, rand_hold());
        axi_write(`EE_REG_CTRL, 32'h3, rand_hold());  // read go while busy
        axi_read(`EE_REG_STATUS, rand_hold(), rd);
        expect_value("busy", 32'h1, {31'd0, rd[0]});
        while (!rd[1])
            axi_read(`EE_REG_STATUS, rand_hold(), rd);
        expect_value("write flags", 32'h2, {29'd0, rd[2:0]});
        repeat (XFER_CYCLES)
            @(negedge CLK);  // room for a queued transfer to reach its stop
        expect_value("transfers on the bus", 32'd1, 32'(ee_stops - stops0));
        written[a]  = 1'b1;
        ref_data[a] = d;
        run_xfer(a, 8'h00, 1'b1, rand_hold(), rd);
        expect_value("read data", {24'd0, ref_byte(a)}, {24'd0, rd[15:8]});
        end_test(errs);

        afails = DUT.u_asserts.fail_count;  // bound checker
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
        if (errors == 0 && afails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/eeprom_pkg.sv
verilog/axil_regs.sv
verilog/i2c_ctrl.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_i2c_top.sv
testbench/eeprom_model.sv
testbench/eeprom_i2c_asserts.sv
testbench/tb_eeprom_i2c.sv
